/* design/dbg_pkg.sv */
package dbg_pkg;

    // widths with a meaning
    typedef logic [7:0]  byte_t;        // one uart byte
    typedef logic [31:0] word_t;        // instruction, alu result, mem data
    typedef logic [7:0]  mem_addr_t;    // mem/wb data address
    typedef logic [18:0] ctrl_flags_t;  // control and forward flags

    // command bytes from the host
    localparam byte_t CMD_LOAD      = 8'h01;
    localparam byte_t CMD_DEBUG     = 8'h02;
    localparam byte_t CMD_RUN       = 8'h04;
    localparam byte_t CMD_STEP      = 8'h08;
    localparam byte_t CMD_END_DEBUG = 8'h10;

    localparam int INSTR_BYTES = 4;     // bytes per instruction word

    // snapshot layout, lsb group first
    localparam int SNAP_BYTES    = 12;
    localparam int SNAP_BITS     = SNAP_BYTES * 8;
    localparam int ALU_BITS      = 32;            // ex/mem group
    localparam int MEMWB_BITS    = 40;            // addr byte then mem data
    localparam int CTRL_PAD_BITS = 5;             // zero pad under the flags

    // mode fsm of the command decoder
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        RUN,
        DEBUG,
        DUMP
    } mode_state_e;

    // byte sender fsm
    typedef enum logic [1:0] {
        S_IDLE,
        S_SEND,
        S_WAIT
    } send_state_e;

endpackage

/* design/cmd_decoder.sv */
`timescale 1ns/10ps

module cmd_decoder
    import dbg_pkg::*;
(
    input  logic  clk,
    input  logic  i_rst_n,
    input  logic  i_rx_done,      // one cycle strobe from uart rx
    input  byte_t i_rx_byte,
    input  logic  i_prog_end,     // pipeline reached end of program
    input  logic  i_load_halt,    // loader saw the halt word
    input  logic  i_dump_done,    // sender finished the snapshot
    output logic  o_load_en,
    output logic  o_load_begin,
    output logic  o_dump_req,
    output logic  o_run,
    output logic  o_step
);

    mode_state_e state;
    mode_state_e next_state;
    logic        debug_q;
    logic        next_debug;
    logic        step_go;
    logic        load_begin_q;
    logic        dump_req_q;
    logic        run_q;
    logic        step_q;

    always_comb begin
        next_state = state;
        next_debug = debug_q;
        step_go    = 1'b0;
        case (state)
            IDLE: begin
                if (i_rx_done) begin
                    case (i_rx_byte)
                        CMD_LOAD: next_state = LOAD;
                        CMD_DEBUG: begin
                            next_state = DEBUG;
                            next_debug = 1'b1;  // dumps come back here
                        end
                        CMD_RUN: begin
                            next_state = RUN;
                            next_debug = 1'b0;
                        end
                        default: next_state = IDLE;
                    endcase
                end
            end
            LOAD: begin
                if (i_load_halt) begin
                    next_state = IDLE;
                end
            end
            RUN: begin
                if (i_prog_end) begin
                    next_state = DUMP;
                end
            end
            DEBUG: begin
                if (i_rx_done) begin
                    case (i_rx_byte)
                        CMD_STEP: begin
                            next_state = DUMP;
                            step_go    = 1'b1;
                        end
                        CMD_END_DEBUG: begin
                            next_state = DUMP;   // last snapshot, then idle
                            next_debug = 1'b0;
                        end
                        default: next_state = DEBUG;
                    endcase
                end
            end
            DUMP: begin
                if (i_dump_done) begin
                    next_state = debug_q ? DEBUG : IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= IDLE;
            debug_q      <= 1'b0;
            load_begin_q <= 1'b0;
            dump_req_q   <= 1'b0;
            run_q        <= 1'b0;
            step_q       <= 1'b0;
        end else begin
            state        <= next_state;
            debug_q      <= next_debug;
            load_begin_q <= (next_state == LOAD) && (state != LOAD);
            dump_req_q   <= (next_state == DUMP) && (state != DUMP);
            // run holds through debug and dump, drops with idle
            run_q        <= (next_state == RUN) || (next_state == DEBUG) ||
                            (next_state == DUMP);
            step_q       <= step_go;
        end
    end

    assign o_load_en    = (state == LOAD);
    assign o_load_begin = load_begin_q;
    assign o_dump_req   = dump_req_q;
    assign o_run        = run_q;
    assign o_step       = step_q;

    // a step is only issued for a step byte taken in debug mode
    a_step_from_debug: assert property (@(posedge clk) disable iff (!i_rst_n)
        $rose(o_step) |-> $past(state) == DEBUG)
        else $error("o_step rose outside debug mode");

endmodule

/* design/instr_loader.sv */
`timescale 1ns/10ps

module instr_loader
    import dbg_pkg::*;
#(
    parameter word_t HALT_WORD = '1
) (
    input  logic  clk,
    input  logic  i_rst_n,
    input  logic  i_load_en,      // high for the whole load phase
    input  logic  i_load_begin,   // clears counter and address
    input  logic  i_rx_done,
    input  byte_t i_rx_byte,
    output word_t o_instr,
    output word_t o_instr_addr,
    output logic  o_instr_valid,
    output logic  o_load_halt
);

    word_t      word_q;
    word_t      word_next;
    logic [1:0] byte_cnt;
    logic       last_byte;
    word_t      addr_q;
    logic       valid_q;
    logic       halt_q;

    assign word_next = {word_q[23:0], i_rx_byte};   // msb arrives first
    assign last_byte = i_load_en && i_rx_done && (byte_cnt == 2'(INSTR_BYTES - 1));

    always_ff @(posedge clk) begin
        if (i_load_en && i_rx_done) begin
            word_q <= word_next;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            byte_cnt <= '0;
            addr_q   <= '0;
            valid_q  <= 1'b0;
            halt_q   <= 1'b0;
        end else begin
            valid_q <= last_byte && (word_next != HALT_WORD);
            halt_q  <= last_byte && (word_next == HALT_WORD);
            if (i_load_begin) begin
                byte_cnt <= '0;
                addr_q   <= '0;
            end else begin
                if (i_load_en && i_rx_done) begin
                    byte_cnt <= byte_cnt + 2'd1;   // wraps after the 4th byte
                end
                if (valid_q) begin
                    addr_q <= addr_q + word_t'(INSTR_BYTES);  // next slot
                end
            end
        end
    end

    assign o_instr       = word_q;
    assign o_instr_addr  = addr_q;
    assign o_instr_valid = valid_q;
    assign o_load_halt   = halt_q;

    // halt word must never reach instruction memory
    a_no_halt_write: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_instr_valid |-> (o_instr != HALT_WORD))
        else $error("halt word presented as a valid instruction");

endmodule

/* design/snapshot_sender.sv */
`timescale 1ns/10ps

module snapshot_sender
    import dbg_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_dump_req,     // one cycle, capture and start
    input  logic        i_tx_done,      // uart tx finished a byte
    input  word_t       i_alu_result,
    input  word_t       i_mem_data,
    input  mem_addr_t   i_mem_addr,
    input  ctrl_flags_t i_ctrl_flags,
    output logic        o_tx_start,
    output byte_t       o_tx_byte,
    output logic        o_dump_done
);

    send_state_e          state;
    logic [SNAP_BITS-1:0] snap_q;
    logic [SNAP_BITS-1:0] snap_in;
    logic [3:0]           byte_idx;
    logic                 last_ack;
    logic                 done_q;

    // byte 0 is the alu lsb, control group ends up on top
    assign snap_in = {
        i_ctrl_flags,
        {CTRL_PAD_BITS{1'b0}},
        i_mem_data,
        i_mem_addr,
        i_alu_result
    };

    assign last_ack = (state == S_WAIT) && i_tx_done &&
                      (byte_idx == 4'(SNAP_BYTES - 1));

    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && i_dump_req) begin
            snap_q <= snap_in;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= S_IDLE;
            byte_idx <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= last_ack;
            case (state)
                S_IDLE: begin
                    if (i_dump_req) begin
                        byte_idx <= '0;
                        state    <= S_SEND;
                    end
                end
                S_SEND: begin
                    state <= S_WAIT;   // start lasts one cycle
                end
                S_WAIT: begin
                    if (i_tx_done) begin
                        if (last_ack) begin
                            state <= S_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 4'd1;
                            state    <= S_SEND;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign o_tx_start  = (state == S_SEND);
    assign o_tx_byte   = snap_q[byte_idx*8 +: 8];   // held until next start
    assign o_dump_done = done_q;

    // one byte outstanding, so starts are always separated
    a_start_single: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_tx_start |=> !o_tx_start)
        else $error("o_tx_start high on consecutive cycles");

endmodule

/* design/uart_debug_top.sv */
`timescale 1ns/10ps

module uart_debug_top
    import dbg_pkg::*;
#(
    parameter word_t HALT_WORD = '1
) (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_rx_done,
    input  byte_t       i_rx_byte,
    input  logic        i_tx_done,
    input  logic        i_prog_end,
    input  word_t       i_alu_result,
    input  word_t       i_mem_data,
    input  mem_addr_t   i_mem_addr,
    input  ctrl_flags_t i_ctrl_flags,
    output logic        o_tx_start,
    output byte_t       o_tx_byte,
    output word_t       o_instr,
    output word_t       o_instr_addr,
    output logic        o_instr_valid,
    output logic        o_run,
    output logic        o_step
);

    logic load_en;
    logic load_begin;
    logic load_halt;
    logic dump_req;
    logic dump_done;

    cmd_decoder u_decoder (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_rx_done    (i_rx_done),
        .i_rx_byte    (i_rx_byte),
        .i_prog_end   (i_prog_end),
        .i_load_halt  (load_halt),
        .i_dump_done  (dump_done),
        .o_load_en    (load_en),
        .o_load_begin (load_begin),
        .o_dump_req   (dump_req),
        .o_run        (o_run),
        .o_step       (o_step)
    );

    instr_loader #(
        .HALT_WORD (HALT_WORD)
    ) u_loader (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_load_en     (load_en),
        .i_load_begin  (load_begin),
        .i_rx_done     (i_rx_done),
        .i_rx_byte     (i_rx_byte),
        .o_instr       (o_instr),
        .o_instr_addr  (o_instr_addr),
        .o_instr_valid (o_instr_valid),
        .o_load_halt   (load_halt)
    );

    snapshot_sender u_sender (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_dump_req   (dump_req),
        .i_tx_done    (i_tx_done),
        .i_alu_result (i_alu_result),
        .i_mem_data   (i_mem_data),
        .i_mem_addr   (i_mem_addr),
        .i_ctrl_flags (i_ctrl_flags),
        .o_tx_start   (o_tx_start),
        .o_tx_byte    (o_tx_byte),
        .o_dump_done  (dump_done)
    );

endmodule

/* tb/dbg_checker.sv */
`timescale 1ns/10ps

module dbg_checker
    import dbg_pkg::*;
(
    input logic        clk,
    input logic        i_tx_start,
    input byte_t       i_tx_byte,
    input logic        i_tx_done,
    input word_t       i_instr,
    input word_t       i_instr_addr,
    input logic        i_instr_valid,
    input logic        i_run,
    input logic        i_step,
    input word_t       i_alu_result,
    input word_t       i_mem_data,
    input mem_addr_t   i_mem_addr,
    input ctrl_flags_t i_ctrl_flags
);

    int          err_count     = 0;
    int          snaps_pending = 0;   // snapshots the tb has triggered
    int          steps_pending = 0;
    logic        run_hold      = 1'b0; // o_run must stay high
    logic        quiet         = 1'b1; // all control outputs must stay low
    word_t       exp_words[$];
    word_t       exp_addrs[$];
    int          byte_idx      = 0;
    logic        tx_outstanding = 1'b0;
    logic        step_prev     = 1'b0;
    word_t       exp_w;
    word_t       exp_a;
    byte_t       exp_b;
    word_t       snap_alu;
    word_t       snap_data;
    mem_addr_t   snap_addr;
    ctrl_flags_t snap_flags;

    // bytes in arrival order, msb first
    function automatic word_t expected_word(input byte_t b0, input byte_t b1,
                                            input byte_t b2, input byte_t b3);
        return {b0, b1, b2, b3};
    endfunction

    // alu lsb first, then addr byte and mem data, then flags over 5 zero bits
    function automatic byte_t expected_snapshot_byte(input int idx, input word_t alu,
                                                     input mem_addr_t maddr,
                                                     input word_t mdata,
                                                     input ctrl_flags_t flags);
        logic [23:0] ctrl;
        word_t       sh;
        ctrl = {flags, 5'b00000};
        if (idx < 4) begin
            sh = alu >> (8 * idx);
        end else if (idx == 4) begin
            sh = {24'h0, maddr};
        end else if (idx < 9) begin
            sh = mdata >> (8 * (idx - 5));
        end else begin
            sh = {8'h0, ctrl} >> (8 * (idx - 9));
        end
        return sh[7:0];
    endfunction

    task automatic value_error(input string name, input word_t exp, input word_t act);
        err_count++;
        $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    endtask

    task automatic plain_error(input string msg);
        err_count++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic expect_word(input byte_t b0, input byte_t b1, input byte_t b2,
                               input byte_t b3, input word_t addr);
        exp_words.push_back(expected_word(b0, b1, b2, b3));
        exp_addrs.push_back(addr);
    endtask

    task automatic expect_snapshot();
        snaps_pending++;
    endtask

    task automatic expect_step();
        steps_pending++;
    endtask

    task automatic final_check();
        if (exp_words.size() != 0) plain_error("some instruction words never appeared");
        if (steps_pending != 0) plain_error("some step bytes gave no o_step pulse");
        if (snaps_pending != 0) plain_error("some snapshots were never sent");
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (quiet && (i_run || i_step || i_tx_start || i_instr_valid))
            plain_error("control output active while the controller is idle");
        if (run_hold && !i_run)
            value_error("o_run", 32'd1, 32'd0);
        if (i_instr_valid) begin
            if (exp_words.size() == 0) begin
                plain_error("o_instr_valid pulse with no word pending");
            end else begin
                exp_w = exp_words.pop_front();
                exp_a = exp_addrs.pop_front();
                if (i_instr != exp_w) value_error("o_instr", exp_w, i_instr);
                if (i_instr_addr != exp_a) value_error("o_instr_addr", exp_a, i_instr_addr);
            end
        end
        if (i_step) begin
            if (step_prev) plain_error("o_step high for more than one cycle");
            else if (steps_pending == 0) plain_error("o_step pulse with no step byte sent");
            else steps_pending--;
        end
        step_prev = i_step;
        if (i_tx_start) begin
            if (tx_outstanding)
                plain_error("o_tx_start before i_tx_done of the previous byte");
            tx_outstanding = 1'b1;
            if (snaps_pending == 0) begin
                plain_error("o_tx_start with no snapshot pending");
            end else begin
                if (byte_idx == 0) begin   // pipeline state is held during a dump
                    snap_alu   = i_alu_result;
                    snap_data  = i_mem_data;
                    snap_addr  = i_mem_addr;
                    snap_flags = i_ctrl_flags;
                end
                exp_b = expected_snapshot_byte(byte_idx, snap_alu, snap_addr, snap_data,
                                               snap_flags);
                if (i_tx_byte != exp_b)
                    value_error("o_tx_byte", word_t'(exp_b), word_t'(i_tx_byte));
                byte_idx++;
                if (byte_idx == SNAP_BYTES) begin
                    byte_idx = 0;
                    snaps_pending--;
                end
            end
        end
        if (i_tx_done) tx_outstanding = 1'b0;
    end

endmodule

/* tb/tb_top.sv */
`timescale 1ns/10ps

module tb_top
    import dbg_pkg::*;
();

    // bytes through the rx and tx ports over the whole test list
    localparam int TOTAL_BYTES = 29 + 13 + 53 + 13 + 30;
    localparam int CYCLE_LIMIT = 40 * TOTAL_BYTES + 1000;

    logic        clk;
    logic        i_rst_n;
    logic        i_rx_done;
    byte_t       i_rx_byte;
    logic        i_tx_done;
    logic        i_prog_end;
    word_t       i_alu_result;
    word_t       i_mem_data;
    mem_addr_t   i_mem_addr;
    ctrl_flags_t i_ctrl_flags;
    logic        o_tx_start;
    byte_t       o_tx_byte;
    word_t       o_instr;
    word_t       o_instr_addr;
    logic        o_instr_valid;
    logic        o_run;
    logic        o_step;

    integer seed    = 32'h4ca2;
    int     tx_min  = 1;      // tx model delay range in cycles
    int     tx_span = 6;
    logic   tx_busy = 1'b0;
    int     cycles  = 0;

    uart_debug_top u_dut (
        .clk (clk), .i_rst_n (i_rst_n), .i_rx_done (i_rx_done), .i_rx_byte (i_rx_byte),
        .i_tx_done (i_tx_done), .i_prog_end (i_prog_end), .i_alu_result (i_alu_result),
        .i_mem_data (i_mem_data), .i_mem_addr (i_mem_addr), .i_ctrl_flags (i_ctrl_flags),
        .o_tx_start (o_tx_start), .o_tx_byte (o_tx_byte), .o_instr (o_instr),
        .o_instr_addr (o_instr_addr), .o_instr_valid (o_instr_valid), .o_run (o_run),
        .o_step (o_step)
    );

    dbg_checker u_chk (
        .clk (clk), .i_tx_start (o_tx_start), .i_tx_byte (o_tx_byte), .i_tx_done (i_tx_done),
        .i_instr (o_instr), .i_instr_addr (o_instr_addr), .i_instr_valid (o_instr_valid),
        .i_run (o_run), .i_step (o_step), .i_alu_result (i_alu_result),
        .i_mem_data (i_mem_data), .i_mem_addr (i_mem_addr), .i_ctrl_flags (i_ctrl_flags)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // uart transmitter model with one done strobe per start
    initial begin
        int delay;
        forever begin
            @(negedge clk);
            if (o_tx_start) begin
                tx_busy = 1'b1;
                delay = tx_min + int'($unsigned($random(seed)) % tx_span);
                repeat (delay) @(posedge clk);
                #2 i_tx_done = 1'b1;
                shuffle_pipeline();   // pipeline moves on while the snapshot goes out
                @(posedge clk);
                #2 i_tx_done = 1'b0;
                tx_busy = 1'b0;
            end
        end
    end

    // all tasks start and end 2 ns after a rising edge
    task automatic send_byte(input byte_t b, input logic hold_run);
        i_rx_byte = b;
        i_rx_done = 1'b1;
        @(posedge clk);
        #2 i_rx_done = 1'b0;
        if (hold_run) u_chk.run_hold = 1'b1;   // o_run high from here on
        repeat (1 + int'($unsigned($random(seed)) % 3)) @(posedge clk);
        #2;
    endtask

    task automatic command(input byte_t b, input logic hold_run);
        u_chk.quiet = 1'b0;
        send_byte(b, hold_run);
    endtask

    task automatic settle();
        repeat (3) @(posedge clk);
        #2 u_chk.quiet = 1'b1;
    endtask

    // fresh random pipeline state
    task automatic shuffle_pipeline();
        word_t r;
        i_alu_result = $random(seed);
        i_mem_data   = $random(seed);
        r = $random(seed);
        i_mem_addr   = r[7:0];
        r = $random(seed);
        i_ctrl_flags = r[18:0];
    endtask

    task automatic set_pipeline();
        shuffle_pipeline();
        u_chk.expect_snapshot();
    endtask

    task automatic wait_dump();
        wait (u_chk.snaps_pending == 0);
        @(posedge clk);
        wait (!tx_busy);
        @(posedge clk);
        #2;
    endtask

    task automatic load_program(input int n_words);
        word_t w;
        command(CMD_LOAD, 1'b0);
        for (int i = 0; i < n_words; i++) begin
            w = $random(seed);
            if (w == '1) w = '0;   // keep the halt pattern out of the data
            u_chk.expect_word(w[31:24], w[23:16], w[15:8], w[7:0], word_t'(4 * i));
            for (int k = 3; k >= 0; k--) send_byte(w[8*k +: 8], 1'b0);
        end
        repeat (INSTR_BYTES) send_byte(8'hff, 1'b0);
        settle();
    endtask

    task automatic debug_session(input int n_steps, input logic junk);
        command(CMD_DEBUG, 1'b1);
        for (int i = 0; i < n_steps; i++) begin
            set_pipeline();
            u_chk.expect_step();
            command(CMD_STEP, 1'b0);
            if (junk) begin   // dropped while the dump runs
                send_byte(CMD_STEP, 1'b0);
                send_byte(CMD_LOAD, 1'b0);
                send_byte(CMD_END_DEBUG, 1'b0);
            end
            wait_dump();
            repeat (3) @(posedge clk);
            #2;
        end
        set_pipeline();
        command(CMD_END_DEBUG, 1'b0);
        wait_dump();
        u_chk.run_hold = 1'b0;
        settle();
    endtask

    initial begin
        i_rst_n = 1'b0;
        i_rx_done = 1'b0;
        i_rx_byte = '0;
        i_tx_done = 1'b0;
        i_prog_end = 1'b0;
        i_alu_result = '0;
        i_mem_data = '0;
        i_mem_addr = '0;
        i_ctrl_flags = '0;
        repeat (5) @(posedge clk);
        #2 i_rst_n = 1'b1;
        repeat (5) @(posedge clk);   // outputs must stay low before a command
        #2;
        load_program(6);
        command(CMD_RUN, 1'b1);
        repeat (5) @(posedge clk);
        #2 set_pipeline();
        i_prog_end = 1'b1;
        @(posedge clk);
        #2 i_prog_end = 1'b0;
        wait_dump();
        u_chk.run_hold = 1'b0;
        settle();
        debug_session(3, 1'b0);
        load_program(2);   // addresses restart at 0
        tx_min  = 10;      // slow transmitter
        tx_span = 21;
        debug_session(1, 1'b1);
        u_chk.final_check();
        $display("errors: %0d", u_chk.err_count);
        if (u_chk.err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the test did not complete within %0d cycles", CYCLE_LIMIT);
        $display("errors: %0d", u_chk.err_count);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* list.f */
design/dbg_pkg.sv
design/cmd_decoder.sv
design/instr_loader.sv
design/snapshot_sender.sv
design/uart_debug_top.sv
tb/dbg_checker.sv
tb/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the debug controller testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module tb_top \
    --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
